//--- verilog/decode_pkg.sv
`default_nettype none

package decode_pkg;

    typedef logic [31:0] word_t;        // data or address word
    typedef logic [4:0]  reg_addr_t;    // register number
    typedef logic [3:0]  alu_op_t;      // execute stage operation
    typedef logic [2:0]  dmem_info_t;   // [2] unsigned load, [1:0] size
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  func_t;

    // alu operations seen by execute
    localparam alu_op_t alu_add = 4'h0;
    localparam alu_op_t alu_sub = 4'h1;
    localparam alu_op_t alu_and = 4'h2;
    localparam alu_op_t alu_or  = 4'h3;
    localparam alu_op_t alu_xor = 4'h4;
    localparam alu_op_t alu_slt = 4'h5;
    localparam alu_op_t alu_nop = 4'hf;

    localparam opcode_t op_rtype = 6'h00;
    localparam opcode_t op_fp    = 6'h01;   // fp arith, func selects the op
    localparam opcode_t op_j     = 6'h02;
    localparam opcode_t op_jal   = 6'h03;
    localparam opcode_t op_beqz  = 6'h04;
    localparam opcode_t op_bnez  = 6'h05;
    localparam opcode_t op_addi  = 6'h08;
    localparam opcode_t op_andi  = 6'h0c;
    localparam opcode_t op_ori   = 6'h0d;
    localparam opcode_t op_xori  = 6'h0e;
    localparam opcode_t op_jr    = 6'h12;
    localparam opcode_t op_jalr  = 6'h13;

    // func field of r-type and fp arith
    localparam func_t fn_add = 6'h20;
    localparam func_t fn_sub = 6'h22;
    localparam func_t fn_and = 6'h24;
    localparam func_t fn_or  = 6'h25;
    localparam func_t fn_xor = 6'h26;
    localparam func_t fn_slt = 6'h2a;

    localparam reg_addr_t link_reg  = 5'd31;
    localparam word_t     link_step = 32'd4;

    typedef struct packed {
        logic reg_write;    // writes the integer file
        logic fp_write;     // writes the fp file
        logic mem_read;
        logic mem_write;
        logic imm_src;      // operand b is the immediate
        logic link;         // jal / jalr
        logic branch;       // beqz / bnez
    } ctrl_t;

    // one result from a later stage
    typedef struct packed {
        logic      valid;
        logic      fp;
        reg_addr_t addr;
        word_t     value;
    } fwd_t;

    typedef struct packed {
        logic      we;
        logic      fp;      // selects the fp file
        reg_addr_t addr;
        word_t     data;
    } wb_t;

    // id/ex pipeline register contents
    typedef struct packed {
        ctrl_t      ctrl;
        alu_op_t    alu_op;
        word_t      op_a;
        word_t      op_b;
        word_t      imm;
        dmem_info_t dmem;
        reg_addr_t  dest;
        reg_addr_t  src_a;
        reg_addr_t  src_b;
    } id_ex_t;

endpackage

`default_nettype wire

//--- verilog/decode_control.sv
`default_nettype none

module decode_control #(
    parameter int unsigned LINK_BUBBLES = 2,
    parameter int unsigned LOAD_BUBBLES = 9
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   stall,
    input  decode_pkg::word_t      instruction,
    output decode_pkg::ctrl_t      ctrl,
    output decode_pkg::alu_op_t    alu_op,
    output decode_pkg::dmem_info_t dmem,
    output logic                   insert_bubble,
    output logic                   fetch_hold
);

    localparam int unsigned MAX_BUBBLES =
        (LOAD_BUBBLES > LINK_BUBBLES) ? LOAD_BUBBLES : LINK_BUBBLES;
    localparam int CNT_W = $clog2(MAX_BUBBLES + 2);

    typedef logic [CNT_W-1:0] cnt_t;

    typedef enum logic [1:0] {
        st_idle,
        st_link_wait,
        st_load_wait
    } state_t;

    state_t                state;
    cnt_t                  count;       // bubbles still to insert
    decode_pkg::opcode_t   opcode;
    decode_pkg::func_t     func;
    decode_pkg::alu_op_t   func_op;

    function automatic decode_pkg::alu_op_t func_to_alu(input decode_pkg::func_t fn);
        decode_pkg::alu_op_t op;
        case (fn)
            decode_pkg::fn_add: op = decode_pkg::alu_add;
            decode_pkg::fn_sub: op = decode_pkg::alu_sub;
            decode_pkg::fn_and: op = decode_pkg::alu_and;
            decode_pkg::fn_or:  op = decode_pkg::alu_or;
            decode_pkg::fn_xor: op = decode_pkg::alu_xor;
            decode_pkg::fn_slt: op = decode_pkg::alu_slt;
            default:            op = decode_pkg::alu_nop;   // unknown func
        endcase
        return op;
    endfunction

    assign opcode  = instruction[31:26];
    assign func    = instruction[5:0];
    assign func_op = func_to_alu(func);

    always_comb
    begin
        ctrl   = '0;
        alu_op = decode_pkg::alu_nop;
        dmem   = '0;
        case (opcode)
            decode_pkg::op_rtype:
            begin
                ctrl.reg_write = (func_op != decode_pkg::alu_nop);
                alu_op         = func_op;
            end
            decode_pkg::op_fp:
            begin
                ctrl.fp_write = (func_op != decode_pkg::alu_nop);
                alu_op        = func_op;
            end
            decode_pkg::op_addi, decode_pkg::op_andi,
            decode_pkg::op_ori, decode_pkg::op_xori:
            begin
                ctrl.reg_write = 1'b1;
                ctrl.imm_src   = 1'b1;
                case (opcode)
                    decode_pkg::op_andi: alu_op = decode_pkg::alu_and;
                    decode_pkg::op_ori:  alu_op = decode_pkg::alu_or;
                    decode_pkg::op_xori: alu_op = decode_pkg::alu_xor;
                    default:             alu_op = decode_pkg::alu_add;
                endcase
            end
            decode_pkg::op_beqz, decode_pkg::op_bnez:
                ctrl.branch = 1'b1;                 // resolved here, nothing for execute
            decode_pkg::op_jal, decode_pkg::op_jalr:
            begin
                ctrl.reg_write = 1'b1;
                ctrl.link      = 1'b1;
                alu_op         = decode_pkg::alu_add;   // pc_plus_four + 4
            end
            default:
            begin
                if (opcode[5:4] == 2'b10)           // 100xxx load, 101xxx store
                begin
                    ctrl.reg_write = ~opcode[3];
                    ctrl.mem_read  = ~opcode[3];
                    ctrl.mem_write = opcode[3];
                    ctrl.imm_src   = 1'b1;
                    alu_op         = decode_pkg::alu_add;
                    dmem           = opcode[2:0];
                end
            end
        endcase
    end

    // bubble sequencing, a new hold starts only from idle
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= st_idle;
            count <= '0;
        end
        else if (!stall)
        begin
            case (state)
                st_idle:
                begin
                    if (ctrl.link && LINK_BUBBLES != 0)
                    begin
                        state <= st_link_wait;
                        count <= cnt_t'(LINK_BUBBLES);
                    end
                    else if (ctrl.mem_read && LOAD_BUBBLES != 0)
                    begin
                        state <= st_load_wait;
                        count <= cnt_t'(LOAD_BUBBLES);
                    end
                end
                st_link_wait, st_load_wait:
                begin
                    count <= count - 1'b1;
                    if (count == cnt_t'(1))
                        state <= st_idle;           // this edge latches the last bubble
                end
                default:
                    state <= st_idle;
            endcase
        end
    end

    assign insert_bubble = (count != '0);
    assign fetch_hold    = (state != st_idle);

    assert property (@(posedge clk) disable iff (reset)
        (state == st_idle) |-> !insert_bubble);

    // a wait state must never decrement past zero
    assert property (@(posedge clk) disable iff (reset)
        (state != st_idle && !stall) |-> (count != '0));

endmodule

`default_nettype wire

//--- verilog/reg_file.sv
`default_nettype none

module reg_file #(
    parameter bit HARD_ZERO = 1'b1
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  we,
    input  decode_pkg::reg_addr_t wr_addr,
    input  decode_pkg::word_t     wr_data,
    input  decode_pkg::reg_addr_t rd_addr_a,
    input  decode_pkg::reg_addr_t rd_addr_b,
    output decode_pkg::word_t     rd_data_a,
    output decode_pkg::word_t     rd_data_b
);

    decode_pkg::word_t regs [32];
    logic              wr_en;

    assign wr_en = we && !(HARD_ZERO && wr_addr == '0);    // r0 stays zero

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end
        else if (wr_en)
        begin
            regs[wr_addr] <= wr_data;
        end
    end

    // write in the same cycle shows up on the read port
    assign rd_data_a = (HARD_ZERO && rd_addr_a == '0)   ? '0 :
                       (wr_en && wr_addr == rd_addr_a) ? wr_data :
                                                         regs[rd_addr_a];

    assign rd_data_b = (HARD_ZERO && rd_addr_b == '0)   ? '0 :
                       (wr_en && wr_addr == rd_addr_b) ? wr_data :
                                                         regs[rd_addr_b];

endmodule

`default_nettype wire

//--- verilog/branch_unit.sv
`default_nettype none

module branch_unit (
    input  decode_pkg::word_t   instruction,
    input  decode_pkg::word_t   pc_plus_four,
    input  decode_pkg::ctrl_t   ctrl,
    input  decode_pkg::word_t   rs_data,
    input  decode_pkg::fwd_t    fwd_ex,
    input  decode_pkg::fwd_t    fwd_mem,
    output logic                jump_taken,
    output decode_pkg::word_t   target
);

    decode_pkg::opcode_t   opcode;
    decode_pkg::reg_addr_t rs;
    decode_pkg::word_t     rs_value;     // rs after forwarding
    decode_pkg::word_t     branch_target;
    decode_pkg::word_t     jump_target;
    logic                  hit_ex;
    logic                  hit_mem;
    logic                  jump_imm;
    logic                  jump_reg;
    logic                  cond;

    assign opcode = instruction[31:26];
    assign rs     = instruction[25:21];

    // fp results and writes to r0 never forward into the integer rs
    assign hit_ex  = fwd_ex.valid && !fwd_ex.fp && fwd_ex.addr != '0 && fwd_ex.addr == rs;
    assign hit_mem = fwd_mem.valid && !fwd_mem.fp && fwd_mem.addr != '0 &&
                     fwd_mem.addr == rs;

    assign rs_value = hit_ex  ? fwd_ex.value :
                      hit_mem ? fwd_mem.value :
                                rs_data;

    assign jump_imm = (opcode == decode_pkg::op_j) || (opcode == decode_pkg::op_jal);
    assign jump_reg = (opcode == decode_pkg::op_jr) || (opcode == decode_pkg::op_jalr);

    // opcode bit 26 is 0 for beqz, 1 for bnez
    assign cond = (rs_value == '0) ^ instruction[26];

    assign branch_target = pc_plus_four + {{16{instruction[15]}}, instruction[15:0]};
    assign jump_target   = pc_plus_four + {{6{instruction[25]}}, instruction[25:0]};

    assign jump_taken = jump_imm || jump_reg || (ctrl.branch && cond);

    assign target = jump_reg ? rs_value :
                    jump_imm ? jump_target :
                               branch_target;

endmodule

`default_nettype wire

//--- verilog/operand_latch.sv
`default_nettype none

module operand_latch (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   stall,
    input  logic                   insert_bubble,
    input  decode_pkg::word_t      instruction,
    input  decode_pkg::word_t      pc_plus_four,
    input  decode_pkg::ctrl_t      ctrl,
    input  decode_pkg::alu_op_t    alu_op,
    input  decode_pkg::dmem_info_t dmem,
    input  decode_pkg::word_t      int_a,
    input  decode_pkg::word_t      int_b,
    input  decode_pkg::word_t      fp_a,
    input  decode_pkg::word_t      fp_b,
    output decode_pkg::id_ex_t     id_ex
);

    decode_pkg::opcode_t   opcode;
    decode_pkg::reg_addr_t rs;
    decode_pkg::reg_addr_t rt;
    decode_pkg::reg_addr_t rd;
    decode_pkg::reg_addr_t dest;
    decode_pkg::word_t     op_a;
    decode_pkg::word_t     op_b;
    decode_pkg::word_t     imm;
    logic                  zero_ext;

    assign opcode = instruction[31:26];
    assign rs     = instruction[25:21];
    assign rt     = instruction[20:16];
    assign rd     = instruction[15:11];

    // logic immediates zero-extend, everything else sign-extends
    assign zero_ext = (opcode == decode_pkg::op_andi) || (opcode == decode_pkg::op_ori) ||
                      (opcode == decode_pkg::op_xori);
    assign imm = {{16{instruction[15] & ~zero_ext}}, instruction[15:0]};

    assign op_a = ctrl.link     ? pc_plus_four :
                  ctrl.fp_write ? fp_a :
                                  int_a;
    assign op_b = ctrl.link     ? decode_pkg::link_step :
                  ctrl.fp_write ? fp_b :
                                  int_b;

    always_comb
    begin
        if (!(ctrl.reg_write || ctrl.fp_write))
            dest = '0;                          // branches, stores, plain jumps
        else if (ctrl.link)
            dest = decode_pkg::link_reg;
        else if (opcode == decode_pkg::op_rtype || opcode == decode_pkg::op_fp)
            dest = rd;
        else
            dest = rt;
    end

    // control half of the register
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            id_ex.ctrl   <= '0;
            id_ex.alu_op <= decode_pkg::alu_nop;
        end
        else if (!stall)
        begin
            id_ex.ctrl   <= insert_bubble ? '0 : ctrl;
            id_ex.alu_op <= insert_bubble ? decode_pkg::alu_nop : alu_op;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!stall)
        begin
            if (insert_bubble)
            begin
                id_ex.op_a  <= '0;
                id_ex.op_b  <= '0;
                id_ex.imm   <= '0;
                id_ex.dmem  <= '0;
                id_ex.dest  <= '0;
                id_ex.src_a <= '0;
                id_ex.src_b <= '0;
            end
            else
            begin
                id_ex.op_a  <= op_a;
                id_ex.op_b  <= op_b;
                id_ex.imm   <= imm;
                id_ex.dmem  <= dmem;
                id_ex.dest  <= dest;
                id_ex.src_a <= ctrl.link ? '0 : rs;  // link operands come from no register
                id_ex.src_b <= ctrl.link ? '0 : rt;
            end
        end
    end

    // the decoder never targets both files at once
    assert property (@(posedge clk) disable iff (reset)
        !(id_ex.ctrl.reg_write && id_ex.ctrl.fp_write));

endmodule

`default_nettype wire

//--- verilog/decode_stage.sv
`default_nettype none

module decode_stage #(
    parameter int unsigned LINK_BUBBLES = 2,
    parameter int unsigned LOAD_BUBBLES = 9
) (
    input  logic               clk,
    input  logic               reset,
    input  decode_pkg::word_t  instruction,
    input  decode_pkg::word_t  pc_plus_four,
    input  logic               stall,
    input  decode_pkg::wb_t    wb,
    input  decode_pkg::fwd_t   fwd_ex,
    input  decode_pkg::fwd_t   fwd_mem,
    output decode_pkg::id_ex_t id_ex,
    output logic               jump_taken,
    output decode_pkg::word_t  target,
    output logic               fetch_hold
);

    decode_pkg::ctrl_t      ctrl;
    decode_pkg::alu_op_t    alu_op;
    decode_pkg::dmem_info_t dmem;
    logic                   insert_bubble;
    decode_pkg::word_t      int_a;
    decode_pkg::word_t      int_b;
    decode_pkg::word_t      fp_a;
    decode_pkg::word_t      fp_b;

    decode_control #(
        .LINK_BUBBLES (LINK_BUBBLES),
        .LOAD_BUBBLES (LOAD_BUBBLES)
    ) control (
        .clk           (clk),
        .reset         (reset),
        .stall         (stall),
        .instruction   (instruction),
        .ctrl          (ctrl),
        .alu_op        (alu_op),
        .dmem          (dmem),
        .insert_bubble (insert_bubble),
        .fetch_hold    (fetch_hold)
    );

    reg_file #(.HARD_ZERO(1'b1)) int_regs (
        .clk       (clk),
        .reset     (reset),
        .we        (wb.we && !wb.fp),
        .wr_addr   (wb.addr),
        .wr_data   (wb.data),
        .rd_addr_a (instruction[25:21]),
        .rd_addr_b (instruction[20:16]),
        .rd_data_a (int_a),
        .rd_data_b (int_b)
    );

    reg_file #(.HARD_ZERO(1'b0)) fp_regs (      // f0 is an ordinary register
        .clk       (clk),
        .reset     (reset),
        .we        (wb.we && wb.fp),
        .wr_addr   (wb.addr),
        .wr_data   (wb.data),
        .rd_addr_a (instruction[25:21]),
        .rd_addr_b (instruction[20:16]),
        .rd_data_a (fp_a),
        .rd_data_b (fp_b)
    );

    branch_unit branch (
        .instruction  (instruction),
        .pc_plus_four (pc_plus_four),
        .ctrl         (ctrl),
        .rs_data      (int_a),
        .fwd_ex       (fwd_ex),
        .fwd_mem      (fwd_mem),
        .jump_taken   (jump_taken),
        .target       (target)
    );

    operand_latch latch (
        .clk           (clk),
        .reset         (reset),
        .stall         (stall),
        .insert_bubble (insert_bubble),
        .instruction   (instruction),
        .pc_plus_four  (pc_plus_four),
        .ctrl          (ctrl),
        .alu_op        (alu_op),
        .dmem          (dmem),
        .int_a         (int_a),
        .int_b         (int_b),
        .fp_a          (fp_a),
        .fp_b          (fp_b),
        .id_ex         (id_ex)
    );

endmodule

`default_nettype wire

//--- sim/decode_checker.sv
`default_nettype none

module decode_checker #(
    parameter int unsigned LINK_BUBBLES = 2,
    parameter int unsigned LOAD_BUBBLES = 9
) (
    input  logic               clk,
    input  logic               reset,
    input  decode_pkg::word_t  instruction,
    input  decode_pkg::word_t  pc_plus_four,
    input  logic               stall,
    input  decode_pkg::wb_t    wb,
    input  decode_pkg::fwd_t   fwd_ex,
    input  decode_pkg::fwd_t   fwd_mem,
    input  decode_pkg::id_ex_t id_ex,
    input  logic               jump_taken,
    input  decode_pkg::word_t  target,
    input  logic               fetch_hold,
    output int                 errors,
    output int                 checks
);

    timeunit 1ns;
    timeprecision 1ps;

    decode_pkg::word_t  int_model [32];     // reference integer file
    decode_pkg::word_t  fp_model [32];      // reference fp file
    decode_pkg::id_ex_t expected;           // what id_ex should hold now
    int                 bubbles_left;
    logic               hold_expected;
    logic               ready = 1'b0;       // set once the first edge is modelled
    logic               fields_valid = 1'b0; // datapath half has been loaded

    initial
    begin
        errors = 0;
        checks = 0;
    end

    task automatic check_value(input string name, input logic [31:0] expected_value,
                               input logic [31:0] actual_value);
        checks++;
        if (actual_value !== expected_value)
        begin
            errors++;
            $display("ERROR at %0t ns: %s expected %h, actual %h",
                     $time, name, expected_value, actual_value);
        end
    endtask

    // reads see a write-back of the same cycle
    function automatic decode_pkg::word_t read_int(input decode_pkg::reg_addr_t addr);
        if (addr == '0)
            return '0;
        if (wb.we && !wb.fp && wb.addr == addr)
            return wb.data;
        return int_model[addr];
    endfunction

    function automatic decode_pkg::word_t read_fp(input decode_pkg::reg_addr_t addr);
        if (wb.we && wb.fp && wb.addr == addr)
            return wb.data;
        return fp_model[addr];              // f0 is a normal register
    endfunction

    function automatic decode_pkg::alu_op_t alu_for_func(input decode_pkg::func_t fn);
        case (fn)
            6'h20: return decode_pkg::alu_add;
            6'h22: return decode_pkg::alu_sub;
            6'h24: return decode_pkg::alu_and;
            6'h25: return decode_pkg::alu_or;
            6'h26: return decode_pkg::alu_xor;
            6'h2a: return decode_pkg::alu_slt;
            default: return decode_pkg::alu_nop;
        endcase
    endfunction

    function automatic decode_pkg::id_ex_t decode_model(input decode_pkg::word_t instr,
                                                       input decode_pkg::word_t pc4);
        decode_pkg::id_ex_t    e;
        decode_pkg::opcode_t   op;
        decode_pkg::reg_addr_t rs;
        decode_pkg::reg_addr_t rt;
        decode_pkg::reg_addr_t rd;
        logic                  zero_ext;
        op       = instr[31:26];
        rs       = instr[25:21];
        rt       = instr[20:16];
        rd       = instr[15:11];
        zero_ext = 1'b0;
        e        = '0;
        e.alu_op = decode_pkg::alu_nop;
        case (op)
            6'h00:
            begin
                e.alu_op         = alu_for_func(instr[5:0]);
                e.ctrl.reg_write = (e.alu_op != decode_pkg::alu_nop);
            end
            6'h01:
            begin
                e.alu_op        = alu_for_func(instr[5:0]);
                e.ctrl.fp_write = (e.alu_op != decode_pkg::alu_nop);
            end
            6'h08, 6'h0c, 6'h0d, 6'h0e:
            begin
                e.ctrl.reg_write = 1'b1;
                e.ctrl.imm_src   = 1'b1;
                zero_ext         = (op != 6'h08);
                case (op)
                    6'h0c: e.alu_op = decode_pkg::alu_and;
                    6'h0d: e.alu_op = decode_pkg::alu_or;
                    6'h0e: e.alu_op = decode_pkg::alu_xor;
                    default: e.alu_op = decode_pkg::alu_add;
                endcase
            end
            6'h04, 6'h05:
                e.ctrl.branch = 1'b1;
            6'h03, 6'h13:
            begin
                e.ctrl.reg_write = 1'b1;
                e.ctrl.link      = 1'b1;
                e.alu_op         = decode_pkg::alu_add;
            end
            default:
            begin
                if (op[5:4] == 2'b10)       // loads and stores
                begin
                    e.ctrl.reg_write = !op[3];
                    e.ctrl.mem_read  = !op[3];
                    e.ctrl.mem_write = op[3];
                    e.ctrl.imm_src   = 1'b1;
                    e.alu_op         = decode_pkg::alu_add;
                    e.dmem           = op[2:0];
                end
            end
        endcase
        e.imm = zero_ext ? {16'h0000, instr[15:0]} : {{16{instr[15]}}, instr[15:0]};
        if (e.ctrl.link)
            e.dest = 5'd31;
        else if (e.ctrl.reg_write || e.ctrl.fp_write)
            e.dest = (op == 6'h00 || op == 6'h01) ? rd : rt;
        if (e.ctrl.link)
        begin
            e.op_a = pc4;
            e.op_b = 32'd4;                 // src fields stay zero for links
        end
        else
        begin
            e.op_a  = e.ctrl.fp_write ? read_fp(rs) : read_int(rs);
            e.op_b  = e.ctrl.fp_write ? read_fp(rt) : read_int(rt);
            e.src_a = rs;
            e.src_b = rt;
        end
        return e;
    endfunction

    // ex beats mem, fp results and r0 are never forwarded
    function automatic decode_pkg::word_t forwarded_rs(input decode_pkg::reg_addr_t rs);
        if (fwd_ex.valid && !fwd_ex.fp && fwd_ex.addr != '0 && fwd_ex.addr == rs)
            return fwd_ex.value;
        if (fwd_mem.valid && !fwd_mem.fp && fwd_mem.addr != '0 && fwd_mem.addr == rs)
            return fwd_mem.value;
        return read_int(rs);
    endfunction

    task automatic advance_pipeline();
        if (bubbles_left > 0)
        begin
            expected        = '0;
            expected.alu_op = decode_pkg::alu_nop;
            bubbles_left--;
            if (bubbles_left == 0)
                hold_expected = 1'b0;   // last bubble drops the hold
        end
        else
        begin
            expected = decode_model(instruction, pc_plus_four);
            if (expected.ctrl.link && LINK_BUBBLES > 0)
            begin
                bubbles_left  = LINK_BUBBLES;
                hold_expected = 1'b1;
            end
            else if (expected.ctrl.mem_read && LOAD_BUBBLES > 0)
            begin
                bubbles_left  = LOAD_BUBBLES;
                hold_expected = 1'b1;
            end
        end
        fields_valid = 1'b1;
    endtask

    task automatic compare_branch();
        decode_pkg::word_t rs_value;
        decode_pkg::word_t offset16;
        decode_pkg::word_t offset26;
        decode_pkg::word_t dest_pc;
        logic              taken;
        rs_value = forwarded_rs(instruction[25:21]);
        offset16 = {{16{instruction[15]}}, instruction[15:0]};
        offset26 = {{6{instruction[25]}}, instruction[25:0]};
        taken    = 1'b0;
        dest_pc  = '0;
        case (instruction[31:26])
            6'h02, 6'h03:
            begin
                taken   = 1'b1;
                dest_pc = pc_plus_four + offset26;
            end
            6'h12, 6'h13:
            begin
                taken   = 1'b1;
                dest_pc = rs_value;
            end
            6'h04:
            begin
                taken   = (rs_value == '0);         // beqz
                dest_pc = pc_plus_four + offset16;
            end
            6'h05:
            begin
                taken   = (rs_value != '0);         // bnez
                dest_pc = pc_plus_four + offset16;
            end
            default:
                taken = 1'b0;
        endcase
        check_value("jump_taken", taken, jump_taken);
        if (taken)
            check_value("target", dest_pc, target);
    endtask

    always @(posedge clk)
    begin
        ready = 1'b1;
        if (reset)
        begin
            for (int i = 0; i < 32; i++)
            begin
                int_model[i] = '0;
                fp_model[i]  = '0;
            end
            expected        = '0;
            expected.alu_op = decode_pkg::alu_nop;
            bubbles_left    = 0;
            hold_expected   = 1'b0;
            fields_valid    = 1'b0;
        end
        else
        begin
            if (!stall)
                advance_pipeline();     // uses the file contents before this write
            if (wb.we && wb.fp)
                fp_model[wb.addr] = wb.data;
            else if (wb.we && wb.addr != '0)
                int_model[wb.addr] = wb.data;
        end
    end

    // inputs and registers are settled half a cycle after the edge
    always @(negedge clk)
    begin
        if (ready)
        begin
            check_value("id_ex.ctrl", expected.ctrl, id_ex.ctrl);
            check_value("id_ex.alu_op", expected.alu_op, id_ex.alu_op);
            check_value("fetch_hold", hold_expected, fetch_hold);
            if (fields_valid)
            begin
                check_value("id_ex.op_a", expected.op_a, id_ex.op_a);
                check_value("id_ex.op_b", expected.op_b, id_ex.op_b);
                check_value("id_ex.imm", expected.imm, id_ex.imm);
                check_value("id_ex.dmem", expected.dmem, id_ex.dmem);
                check_value("id_ex.dest", expected.dest, id_ex.dest);
                check_value("id_ex.src_a", expected.src_a, id_ex.src_a);
                check_value("id_ex.src_b", expected.src_b, id_ex.src_b);
            end
            compare_branch();
        end
    end

endmodule

`default_nettype wire

//--- sim/decode_tb.sv
`default_nettype none

module decode_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int link_bubbles = 2;
    localparam int load_bubbles = 9;
    localparam int num_cycles   = 4000;
    localparam int clk_period   = 100;
    localparam int watchdog_ns  = (num_cycles + 4) * clk_period * 3 / 2;

    logic               clk;
    logic               reset;
    logic               stall;
    decode_pkg::word_t  instruction;
    decode_pkg::word_t  pc_plus_four;
    decode_pkg::wb_t    wb;
    decode_pkg::fwd_t   fwd_ex;
    decode_pkg::fwd_t   fwd_mem;
    decode_pkg::id_ex_t id_ex;
    logic               jump_taken;
    decode_pkg::word_t  target;
    logic               fetch_hold;
    int                 errors;
    int                 checks;
    integer             seed;

    decode_stage #(
        .LINK_BUBBLES (link_bubbles),
        .LOAD_BUBBLES (load_bubbles)
    ) uut (
        .clk          (clk),
        .reset        (reset),
        .instruction  (instruction),
        .pc_plus_four (pc_plus_four),
        .stall        (stall),
        .wb           (wb),
        .fwd_ex       (fwd_ex),
        .fwd_mem      (fwd_mem),
        .id_ex        (id_ex),
        .jump_taken   (jump_taken),
        .target       (target),
        .fetch_hold   (fetch_hold)
    );

    decode_checker #(
        .LINK_BUBBLES (link_bubbles),
        .LOAD_BUBBLES (load_bubbles)
    ) monitor (
        .clk          (clk),
        .reset        (reset),
        .instruction  (instruction),
        .pc_plus_four (pc_plus_four),
        .stall        (stall),
        .wb           (wb),
        .fwd_ex       (fwd_ex),
        .fwd_mem      (fwd_mem),
        .id_ex        (id_ex),
        .jump_taken   (jump_taken),
        .target       (target),
        .fetch_hold   (fetch_hold),
        .errors       (errors),
        .checks       (checks)
    );

    initial
    begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // mostly r0..r7 so bypass and forward addresses collide often
    function automatic decode_pkg::reg_addr_t pick_reg();
        if (($random(seed) & 3) == 0)
            return 5'($random(seed));
        return 5'($random(seed) & 7);
    endfunction

    function automatic decode_pkg::func_t pick_func();
        case ($random(seed) & 7)
            0: return 6'h20;
            1: return 6'h22;
            2: return 6'h24;
            3: return 6'h25;
            4: return 6'h26;
            5: return 6'h2a;
            6: return 6'($random(seed));    // usually an unknown func
            default: return 6'h20;
        endcase
    endfunction

    function automatic decode_pkg::word_t make_instruction();
        decode_pkg::word_t instr;
        int                kind;
        kind          = $random(seed) & 15;
        instr         = $random(seed);
        instr[25:21]  = pick_reg();
        instr[20:16]  = pick_reg();
        instr[15:11]  = pick_reg();
        case (kind)
            0, 1, 2, 14: instr[31:26] = 6'h00;
            3, 4: instr[31:26] = 6'h01;
            5, 6, 15: instr[31:26] = (($random(seed) & 3) == 0) ? 6'h08 :
                                     6'h0c + 6'($unsigned($random(seed)) % 3);
            7: instr[31:26] = {3'b100, 3'($random(seed))};     // load
            8: instr[31:26] = {3'b101, 3'($random(seed))};     // store
            9, 10: instr[31:26] = 6'h04 | 6'($random(seed) & 1);
            11: instr[31:26] = 6'h02 | 6'($random(seed) & 1);
            12: instr[31:26] = 6'h12 | 6'($random(seed) & 1);
            default: instr[31:26] = 6'($random(seed));          // anything, incl. nops
        endcase
        if (kind <= 4 || kind == 14)
            instr[5:0] = pick_func();
        return instr;
    endfunction

    function automatic decode_pkg::fwd_t make_forward(input decode_pkg::reg_addr_t rs);
        decode_pkg::fwd_t f;
        f.valid = ($random(seed) & 7) < 5;
        f.fp    = ($random(seed) & 3) == 0;
        f.addr  = (($random(seed) & 1) != 0) ? rs : pick_reg();
        f.value = ($random(seed) & 3) == 0 ? '0 : $random(seed);
        return f;
    endfunction

    task automatic drive_random();
        decode_pkg::word_t instr;
        decode_pkg::wb_t   next_wb;
        instr        = make_instruction();
        next_wb.we   = ($random(seed) & 3) != 0;
        next_wb.fp   = ($random(seed) & 1) != 0;
        next_wb.addr = (($random(seed) & 3) == 0) ? instr[25:21] : pick_reg();
        next_wb.data = $random(seed);
        instruction  <= instr;
        pc_plus_four <= $random(seed) & 32'hffff_fffc;
        wb           <= next_wb;
        fwd_ex       <= make_forward(instr[25:21]);
        fwd_mem      <= make_forward(instr[25:21]);
        stall        <= ($random(seed) & 255) < 26;   // about one cycle in ten
    endtask

    initial
    begin
        seed         = 32'h6a53_1f31;
        reset        = 1'b1;
        stall        = 1'b0;
        instruction  = '0;
        pc_plus_four = '0;
        wb           = '0;
        fwd_ex       = '0;
        fwd_mem      = '0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        repeat (num_cycles)
        begin
            @(posedge clk);
            drive_random();
        end
        @(posedge clk);                 // last negedge checks are done
        $display("decode_tb: %0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

    initial
    begin
        #(watchdog_ns);
        $display("timeout: the run did not finish within %0d ns", watchdog_ns);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
verilog/decode_pkg.sv
verilog/decode_control.sv
verilog/reg_file.sv
verilog/branch_unit.sv
verilog/operand_latch.sv
verilog/decode_stage.sv
sim/decode_checker.sv
sim/decode_tb.sv

//--- Bender.yml
package:
  name: decode_stage

sources:
  - verilog/decode_pkg.sv
  - verilog/decode_control.sv
  - verilog/reg_file.sv
  - verilog/branch_unit.sv
  - verilog/operand_latch.sv
  - verilog/decode_stage.sv
  - target: simulation
    files:
      - sim/decode_checker.sv
      - sim/decode_tb.sv
